//--- logic/stream_gen_settings.svh
`ifndef STREAM_GEN_SETTINGS_SVH
`define STREAM_GEN_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath widths
`define STREAM_DATA_WIDTH      32
`define STREAM_LEN_WIDTH       8     // beats minus one.
`define STREAM_DELAY_WIDTH     16
`define STREAM_APB_ADDR_WIDTH  8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register byte offsets
`define STREAM_REG_CTRL        8'h00
`define STREAM_REG_LEN         8'h04
`define STREAM_REG_DELAY       8'h08
`define STREAM_REG_SEED        8'h0C
`define STREAM_REG_STATUS      8'h10

`define STREAM_LFSR_TAPS       32'h80200003  // galois feedback mask.

`endif

//--- logic/stream_gen_pkg.sv
package stream_gen_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // payload pattern selection

  typedef enum logic {
    PAT_COUNT = 1'b0,  // word plus one per beat.
    PAT_LFSR  = 1'b1   // galois shift per beat.
  } pattern_mode_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // packet generator FSM

  typedef enum logic [1:0] {
    GEN_IDLE  = 2'd0,  // waiting for start.
    GEN_DELAY = 2'd1,  // counting down the start delay.
    GEN_SEND  = 2'd2   // beats on the stream.
  } gen_state_e;

endpackage

//--- logic/stream_apb_regs.sv
`timescale 1ns/1ps
`include "stream_gen_settings.svh"

module stream_apb_regs (
  input  logic                                M_AXIS_ACLK,
  input  logic                                M_AXIS_ARESETN,
  input  logic [`STREAM_APB_ADDR_WIDTH-1:0]   paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [`STREAM_DATA_WIDTH-1:0]       pwdata,
  output logic [`STREAM_DATA_WIDTH-1:0]       prdata,
  output logic                                pready,
  output logic                                pslverr,
  input  logic                                busy,
  input  logic                                pkt_done,
  output logic                                start,
  output logic [`STREAM_LEN_WIDTH-1:0]        len,
  output logic [`STREAM_DELAY_WIDTH-1:0]      delay,
  output logic [`STREAM_DATA_WIDTH-1:0]       seed,
  output stream_gen_pkg::pattern_mode_e       mode
);

  import stream_gen_pkg::*;

  logic        access;
  logic        addr_ok;
  logic        wr_en;
  logic [15:0] pkt_cnt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // access decode

  assign access = psel && penable;  // no wait states.
  assign pready = access;

  always_comb begin
    case (paddr)
      `STREAM_REG_CTRL,
      `STREAM_REG_LEN,
      `STREAM_REG_DELAY,
      `STREAM_REG_SEED,
      `STREAM_REG_STATUS: addr_ok = 1'b1;
      default:            addr_ok = 1'b0;
    endcase
  end

  // status is read only.
  assign pslverr = access && (!addr_ok || (pwrite && paddr == `STREAM_REG_STATUS));
  assign wr_en   = access && pwrite && !pslverr;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // configuration and start pulse

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      start <= 1'b0;
      len   <= '0;
      delay <= '0;
      seed  <= '0;
      mode  <= PAT_COUNT;
    end else begin
      start <= wr_en && paddr == `STREAM_REG_CTRL && pwdata[0];  // one cycle.
      if (wr_en) begin
        case (paddr)
          `STREAM_REG_CTRL:  mode  <= pattern_mode_e'(pwdata[1]);
          `STREAM_REG_LEN:   len   <= pwdata[`STREAM_LEN_WIDTH-1:0];
          `STREAM_REG_DELAY: delay <= pwdata[`STREAM_DELAY_WIDTH-1:0];
          `STREAM_REG_SEED:  seed  <= pwdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      pkt_cnt <= '0;
    end else if (pkt_done) begin
      pkt_cnt <= pkt_cnt + 16'd1;  // wraps.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read mux

  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (paddr)
        `STREAM_REG_CTRL:   prdata = {30'd0, mode, 1'b0};  // start reads 0.
        `STREAM_REG_LEN:    prdata = {{(`STREAM_DATA_WIDTH-`STREAM_LEN_WIDTH){1'b0}}, len};
        `STREAM_REG_DELAY:  prdata = {{(`STREAM_DATA_WIDTH-`STREAM_DELAY_WIDTH){1'b0}}, delay};
        `STREAM_REG_SEED:   prdata = seed;
        `STREAM_REG_STATUS: prdata = {pkt_cnt, 15'd0, busy};
        default:            prdata = '0;
      endcase
    end
  end

  a_start_pulse: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    start |=> !start
  );

endmodule

//--- logic/stream_pattern_src.sv
`timescale 1ns/1ps
`include "stream_gen_settings.svh"

module stream_pattern_src (
  input  logic                             M_AXIS_ACLK,
  input  logic                             M_AXIS_ARESETN,
  input  logic                             load,
  input  logic                             next,
  input  logic [`STREAM_DATA_WIDTH-1:0]    seed,
  input  stream_gen_pkg::pattern_mode_e    mode,
  output logic [`STREAM_DATA_WIDTH-1:0]    value
);

  import stream_gen_pkg::*;

  pattern_mode_e                 mode_q;
  logic [`STREAM_DATA_WIDTH-1:0] step;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next word

  always_comb begin
    if (mode_q == PAT_LFSR) begin
      // shift right, fold the dropped bit back through the taps.
      step = (value >> 1) ^ (value[0] ? `STREAM_LFSR_TAPS : '0);
    end else begin
      step = value + 1'b1;  // mod 2**32.
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      mode_q <= PAT_COUNT;
    end else if (load) begin
      mode_q <= mode;  // held for the whole packet.
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (load) begin
      value <= seed;
    end else if (next) begin
      value <= step;
    end
  end

  a_load_next_excl: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    !(load && next)
  );

endmodule

//--- logic/stream_pkt_master.sv
`timescale 1ns/1ps
`include "stream_gen_settings.svh"

module stream_pkt_master (
  input  logic                                M_AXIS_ACLK,
  input  logic                                M_AXIS_ARESETN,
  input  logic                                start,
  input  logic [`STREAM_LEN_WIDTH-1:0]        len,
  input  logic [`STREAM_DELAY_WIDTH-1:0]      delay,
  output logic                                busy,
  output logic                                pkt_done,
  output logic                                load,
  output logic                                next,
  input  logic [`STREAM_DATA_WIDTH-1:0]       value,
  output logic                                M_AXIS_TVALID,
  output logic [`STREAM_DATA_WIDTH-1:0]       M_AXIS_TDATA,
  output logic [`STREAM_DATA_WIDTH/8-1:0]     M_AXIS_TSTRB,
  output logic                                M_AXIS_TLAST,
  input  logic                                M_AXIS_TREADY
);

  import stream_gen_pkg::*;

  gen_state_e                     state_q;
  logic [`STREAM_DELAY_WIDTH-1:0] delay_cnt;
  logic [`STREAM_LEN_WIDTH-1:0]   beat_cnt;
  logic [`STREAM_LEN_WIDTH-1:0]   len_q;
  logic                           accept;
  logic                           fill;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake and output register control

  assign accept = M_AXIS_TVALID && M_AXIS_TREADY;

  // the first beat is fetched as the delay runs out, so tvalid
  // rises together with the move into GEN_SEND.
  assign fill = (state_q == GEN_DELAY && delay_cnt == '0) ||
                (state_q == GEN_SEND && (!M_AXIS_TVALID || M_AXIS_TREADY) && !M_AXIS_TLAST);

  assign load     = start && state_q == GEN_IDLE;  // start while busy is dropped.
  assign next     = fill;
  assign pkt_done = accept && M_AXIS_TLAST;
  assign busy     = state_q != GEN_IDLE;

  assign M_AXIS_TSTRB = '1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // FSM and counters

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state_q       <= GEN_IDLE;
      delay_cnt     <= '0;
      beat_cnt      <= '0;
      len_q         <= '0;
      M_AXIS_TVALID <= 1'b0;
      M_AXIS_TLAST  <= 1'b0;
    end else begin
      case (state_q)
        GEN_IDLE: begin
          if (start) begin
            state_q   <= GEN_DELAY;
            delay_cnt <= delay;
            len_q     <= len;  // captured at start.
            beat_cnt  <= '0;
          end
        end
        GEN_DELAY: begin
          if (delay_cnt == '0) begin
            state_q <= GEN_SEND;
          end else begin
            delay_cnt <= delay_cnt - 1'b1;
          end
        end
        GEN_SEND: begin
          if (pkt_done) begin
            state_q <= GEN_IDLE;
          end
        end
        default: state_q <= GEN_IDLE;
      endcase

      if (fill) begin
        M_AXIS_TVALID <= 1'b1;
        M_AXIS_TLAST  <= beat_cnt == len_q;  // last beat is index len.
        beat_cnt      <= beat_cnt + 1'b1;
      end else if (accept) begin
        M_AXIS_TVALID <= 1'b0;
        M_AXIS_TLAST  <= 1'b0;
      end
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (fill) begin
      M_AXIS_TDATA <= value;
    end
  end

  a_hold_on_stall: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (M_AXIS_TVALID && !M_AXIS_TREADY) |=>
      (M_AXIS_TVALID && $stable(M_AXIS_TDATA) && $stable(M_AXIS_TLAST))
  );

  a_valid_in_send: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    M_AXIS_TVALID |-> state_q == GEN_SEND
  );

endmodule

//--- logic/stream_gen_top.sv
`timescale 1ns/1ps
`include "stream_gen_settings.svh"

module stream_gen_top (
  input  logic                                M_AXIS_ACLK,
  input  logic                                M_AXIS_ARESETN,
  input  logic [`STREAM_APB_ADDR_WIDTH-1:0]   paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [`STREAM_DATA_WIDTH-1:0]       pwdata,
  output logic [`STREAM_DATA_WIDTH-1:0]       prdata,
  output logic                                pready,
  output logic                                pslverr,
  output logic                                M_AXIS_TVALID,
  output logic [`STREAM_DATA_WIDTH-1:0]       M_AXIS_TDATA,
  output logic [`STREAM_DATA_WIDTH/8-1:0]     M_AXIS_TSTRB,
  output logic                                M_AXIS_TLAST,
  input  logic                                M_AXIS_TREADY
);

  import stream_gen_pkg::*;

  logic                           start;
  logic [`STREAM_LEN_WIDTH-1:0]   len;
  logic [`STREAM_DELAY_WIDTH-1:0] delay;
  logic [`STREAM_DATA_WIDTH-1:0]  seed;
  pattern_mode_e                  mode;
  logic                           busy;
  logic                           pkt_done;
  logic                           load;
  logic                           next;
  logic [`STREAM_DATA_WIDTH-1:0]  value;

  stream_apb_regs regs_i (
    .M_AXIS_ACLK, .M_AXIS_ARESETN,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .busy, .pkt_done,
    .start, .len, .delay, .seed, .mode
  );

  stream_pattern_src pat_i (
    .M_AXIS_ACLK, .M_AXIS_ARESETN,
    .load, .next, .seed, .mode, .value
  );

  stream_pkt_master mst_i (
    .M_AXIS_ACLK, .M_AXIS_ARESETN,
    .start, .len, .delay,
    .busy, .pkt_done,
    .load, .next, .value,
    .M_AXIS_TVALID, .M_AXIS_TDATA, .M_AXIS_TSTRB, .M_AXIS_TLAST,
    .M_AXIS_TREADY
  );

endmodule

//--- tests/stream_gen_tb.sv
`timescale 1ns/1ps
`include "stream_gen_settings.svh"

module stream_gen_tb;

  localparam int          clk_period = 8;
  localparam int          n_pkts     = 22;
  localparam int          rdy_depth  = 1024;
  localparam logic [31:0] lfsr_taps  = 32'h80200003;

  logic                               clk;
  logic                               rst_n;
  logic [`STREAM_APB_ADDR_WIDTH-1:0]  paddr;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [`STREAM_DATA_WIDTH-1:0]      pwdata;
  logic [`STREAM_DATA_WIDTH-1:0]      prdata;
  logic                               pready;
  logic                               pslverr;
  logic                               tvalid;
  logic [`STREAM_DATA_WIDTH-1:0]      tdata;
  logic [`STREAM_DATA_WIDTH/8-1:0]    tstrb;
  logic                               tlast;
  logic                               tready;

  int          pk_len   [n_pkts];
  int          pk_delay [n_pkts];
  logic [31:0] pk_seed  [n_pkts];
  logic        pk_mode  [n_pkts];
  logic        rdy_pat  [rdy_depth];  // precomputed tready pattern.
  logic [31:0] exp_q [$];
  int          exp_last;
  logic        rand_ready;
  string       cur_test;
  int          cycle_limit;
  int          main_errors;
  int          test_errors_start;
  int          n_tests;
  int          pkts_before;
  int          beats_before;

  int          pkts_seen;
  int          beats_total;
  int          beat_idx;
  int          mon_errors;
  int          rdy_idx;
  logic        stall_pending;
  logic [31:0] stall_data;
  logic        stall_last;
  int          cycles;

  stream_gen_top dut_i (
    .M_AXIS_ACLK(clk), .M_AXIS_ARESETN(rst_n),
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .M_AXIS_TVALID(tvalid), .M_AXIS_TDATA(tdata), .M_AXIS_TSTRB(tstrb),
    .M_AXIS_TLAST(tlast), .M_AXIS_TREADY(tready)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and helpers

  function automatic logic [31:0] step_word(input logic [31:0] w, input logic lfsr);
    if (!lfsr) begin
      return w + 1;  // wraps at 2**32.
    end
    return w[0] ? ((w >> 1) ^ lfsr_taps) : (w >> 1);
  endfunction

  task automatic note_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    $display("MISMATCH %s: %s expected %h actual %h", cur_test, what, exp, act);
    main_errors++;
  endtask

  task automatic apb_transfer(input logic [`STREAM_APB_ADDR_WIDTH-1:0] addr, input logic wr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);  // end of access phase.
    if (pready !== 1'b1) begin
      $display("ERROR %s: pready low in access phase at 0x%02h", cur_test, addr);
      main_errors++;
    end
    rdata   = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`STREAM_APB_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_transfer(addr, 1'b1, data, rd, err);
    if (err !== exp_err) begin
      $display("ERROR %s: pslverr was %b on write to 0x%02h", cur_test, err, addr);
      main_errors++;
    end
  endtask

  task automatic apb_read(input logic [`STREAM_APB_ADDR_WIDTH-1:0] addr,
                          output logic [31:0] data, input logic exp_err);
    logic err;
    apb_transfer(addr, 1'b0, 32'h0, data, err);
    if (err !== exp_err) begin
      $display("ERROR %s: pslverr was %b on read of 0x%02h", cur_test, err, addr);
      main_errors++;
    end
  endtask

  task automatic check_reg(input logic [`STREAM_APB_ADDR_WIDTH-1:0] addr,
                           input logic [31:0] exp, input string what);
    logic [31:0] rd;
    apb_read(addr, rd, 1'b0);
    if (rd !== exp) note_mismatch(what, exp, rd);
  endtask

  task automatic start_packet(input int k);
    logic [31:0] w;
    exp_q.delete();
    w = pk_seed[k];
    for (int i = 0; i <= pk_len[k]; i++) begin
      exp_q.push_back(w);
      w = step_word(w, pk_mode[k]);
    end
    exp_last     = pk_len[k];
    pkts_before  = pkts_seen;
    beats_before = beats_total;
    apb_write(`STREAM_REG_LEN, pk_len[k], 1'b0);
    apb_write(`STREAM_REG_DELAY, pk_delay[k], 1'b0);
    apb_write(`STREAM_REG_SEED, pk_seed[k], 1'b0);
    apb_write(`STREAM_REG_CTRL, {30'd0, pk_mode[k], 1'b1}, 1'b0);
  endtask

  task automatic finish_packet(input int k);
    while (pkts_seen == pkts_before) @(posedge clk);
    if (beats_total - beats_before != pk_len[k] + 1) begin
      note_mismatch("beat count", pk_len[k] + 1, beats_total - beats_before);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test          = name;
    test_errors_start = main_errors + mon_errors;
  endtask

  task automatic end_test();
    n_tests++;
    $display("test %s: %0d errors", cur_test, main_errors + mon_errors - test_errors_start);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tready driver and beat monitor

  initial begin
    tready        = 1'b0;
    rdy_idx       = 0;
    pkts_seen     = 0;
    beats_total   = 0;
    beat_idx      = 0;
    mon_errors    = 0;
    stall_pending = 1'b0;
    forever begin
      @(negedge clk);
      if (stall_pending && (tvalid !== 1'b1 || tdata !== stall_data || tlast !== stall_last)) begin
        $display("ERROR %s: beat changed while tready was low", cur_test);
        mon_errors++;
      end
      if (rand_ready) begin
        tready  = rdy_pat[rdy_idx];
        rdy_idx = (rdy_idx + 1) % rdy_depth;
      end else begin
        tready = 1'b1;
      end
      stall_pending = tvalid && !tready;
      stall_data    = tdata;
      stall_last    = tlast;
      if (tvalid === 1'b1 && tready) begin  // transfer on the coming edge.
        beats_total++;
        if (beat_idx >= exp_q.size()) begin
          $display("ERROR %s: beat %0d arrived with no word expected", cur_test, beat_idx);
          mon_errors++;
        end else if (tdata !== exp_q[beat_idx]) begin
          $display("MISMATCH %s: tdata beat %0d expected %h actual %h",
                   cur_test, beat_idx, exp_q[beat_idx], tdata);
          mon_errors++;
        end
        if (tlast !== (beat_idx == exp_last)) begin
          $display("MISMATCH %s: tlast beat %0d expected %b actual %b",
                   cur_test, beat_idx, beat_idx == exp_last, tlast);
          mon_errors++;
        end
        if (tstrb !== '1) begin
          $display("MISMATCH %s: tstrb expected %h actual %h", cur_test, 4'hf, tstrb);
          mon_errors++;
        end
        if (tlast) begin
          pkts_seen++;
          beat_idx = 0;
        end else begin
          beat_idx++;
        end
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("TIMEOUT: run did not finish within %0d cycles", cycle_limit);
    $display("Done: errors found");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence

  initial begin
    logic [31:0] rd;
    logic [31:0] v_len;
    logic [31:0] v_delay;
    logic [31:0] v_seed;
    rst_n       = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    rand_ready  = 1'b0;
    cur_test    = "reset";
    main_errors = 0;
    n_tests     = 0;
    exp_last    = 0;
    void'($urandom(32'hddf0_3699));
    for (int i = 0; i < rdy_depth; i++) rdy_pat[i] = ($urandom % 10) < 7;
    for (int k = 0; k < 20; k++) begin
      pk_len[k]   = $urandom % 32;
      pk_delay[k] = $urandom % 21;
      pk_seed[k]  = $urandom;
      if (pk_seed[k] == 0) pk_seed[k] = 32'h1;  // lfsr lock-up word.
      pk_mode[k]  = k >= 10;
    end
    pk_len[20]   = 63;
    pk_delay[20] = 200;
    pk_len[21]   = 15;
    pk_delay[21] = 10;
    for (int k = 20; k < n_pkts; k++) begin
      pk_seed[k] = $urandom | 32'h1;
      pk_mode[k] = ($urandom % 2) == 1;
    end
    cycle_limit = 2000;
    for (int k = 0; k < n_pkts; k++) cycle_limit += (pk_delay[k] + pk_len[k] + 1 + 4) * 4;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    begin_test("register readback");
    if (tvalid !== 1'b0 || tlast !== 1'b0 || pslverr !== 1'b0) begin
      $display("ERROR %s: outputs not low after reset", cur_test);
      main_errors++;
    end
    check_reg(`STREAM_REG_STATUS, 32'h0, "STATUS after reset");
    v_len   = $urandom % 256;
    v_delay = $urandom % 65536;
    v_seed  = $urandom;
    apb_write(`STREAM_REG_LEN, v_len, 1'b0);
    apb_write(`STREAM_REG_DELAY, v_delay, 1'b0);
    apb_write(`STREAM_REG_SEED, v_seed, 1'b0);
    apb_write(`STREAM_REG_CTRL, 32'h2, 1'b0);  // lfsr mode, no start.
    check_reg(`STREAM_REG_LEN, v_len, "LEN");
    check_reg(`STREAM_REG_DELAY, v_delay, "DELAY");
    check_reg(`STREAM_REG_SEED, v_seed, "SEED");
    check_reg(`STREAM_REG_CTRL, 32'h2, "CTRL");
    apb_write(8'h14, 32'hffff_ffff, 1'b1);
    apb_read(8'h14, rd, 1'b1);
    apb_write(`STREAM_REG_STATUS, 32'hffff_ffff, 1'b1);
    check_reg(`STREAM_REG_LEN, v_len, "LEN after bad access");
    check_reg(`STREAM_REG_DELAY, v_delay, "DELAY after bad access");
    check_reg(`STREAM_REG_SEED, v_seed, "SEED after bad access");
    end_test();

    begin_test("counter packets");
    for (int k = 0; k < 10; k++) begin
      start_packet(k);
      finish_packet(k);
    end
    end_test();

    begin_test("lfsr backpressure");
    rand_ready = 1'b1;
    for (int k = 10; k < 20; k++) begin
      start_packet(k);
      finish_packet(k);
    end
    end_test();

    begin_test("start while busy");
    start_packet(20);
    apb_write(`STREAM_REG_CTRL, {30'd0, pk_mode[20], 1'b1}, 1'b0);  // still in delay.
    apb_write(`STREAM_REG_LEN, 32'd2, 1'b0);
    while (beats_total == beats_before) @(posedge clk);
    apb_write(`STREAM_REG_CTRL, {30'd0, pk_mode[20], 1'b1}, 1'b0);  // mid packet.
    finish_packet(20);
    pkts_before  = pkts_seen;
    beats_before = beats_total;
    repeat (pk_delay[20] + 20) @(posedge clk);
    if (pkts_seen != pkts_before || beats_total != beats_before) begin
      $display("ERROR %s: extra beats after a start written while busy", cur_test);
      main_errors++;
    end
    end_test();

    begin_test("status");
    check_reg(`STREAM_REG_STATUS, {pkts_seen[15:0], 15'd0, 1'b0}, "STATUS before packet");
    start_packet(21);
    check_reg(`STREAM_REG_STATUS, {pkts_seen[15:0], 15'd0, 1'b1}, "STATUS during packet");
    check_reg(`STREAM_REG_CTRL, {30'd0, pk_mode[21], 1'b0}, "CTRL after start");
    finish_packet(21);
    check_reg(`STREAM_REG_STATUS, {pkts_seen[15:0], 15'd0, 1'b0}, "STATUS after packet");
    end_test();

    $display("tests %0d, beats %0d, packets %0d, errors %0d",
             n_tests, beats_total, pkts_seen, main_errors + mon_errors);
    if (main_errors + mon_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
logic/stream_gen_pkg.sv
logic/stream_apb_regs.sv
logic/stream_pattern_src.sv
logic/stream_pkt_master.sv
logic/stream_gen_top.sv
tests/stream_gen_tb.sv

//--- Makefile
TOP := stream_gen_tb

all: run

build:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
